/* hw/acelp_pkg.sv */
`default_nettype none

// codec-level constants for the fixed codebook stage
package acelp_pkg;

	////////////////////////////////////////////////////////////
	// basic operator word
	////////////////////////////////////////////////////////////
	localparam int OP_W = 16; // Word16 of the reference codec

	////////////////////////////////////////////////////////////
	// subframe and pulse layout
	////////////////////////////////////////////////////////////
	localparam logic [OP_W-1:0] L_SUBFR = 16'd40;  // samples per subframe
	localparam logic [OP_W-1:0] NB_PULSE = 16'd4;  // pulses per subframe

	// pulse amplitudes, chosen by the sign bit
	localparam logic signed [OP_W-1:0] PULSE_POS_AMP = 16'sd8191;  // sign bit set
	localparam logic signed [OP_W-1:0] PULSE_NEG_AMP = -16'sd8192; // sign bit clear

endpackage

`default_nettype wire

/* hw/scratch_map_pkg.sv */
`default_nettype none

// layout of the shared scratch memory
package scratch_map_pkg;

	////////////////////////////////////////////////////////////
	// word and page geometry
	////////////////////////////////////////////////////////////
	localparam int MEM_DATA_W = 32;
	localparam int PAGE_SHIFT = 6; // 64 words per page

	////////////////////////////////////////////////////////////
	// page bases
	////////////////////////////////////////////////////////////
	// index word sits at offset 0
	localparam int INDEX_PAGE = 0;

	// sign word sits at offset 0
	localparam int SIGN_PAGE = 1;

	// cod[0..39] at offsets 0 to 39
	localparam int COD_PAGE = 2;

endpackage

`default_nettype wire

/* hw/basic_op_unit.sv */
`default_nettype none

// 16-bit basic operators of the codec: add, shr, shl
// purely combinational, results are valid in the same cycle
module basic_op_unit (
	input  wire logic [acelp_pkg::OP_W-1:0] add_a_i,
	input  wire logic [acelp_pkg::OP_W-1:0] add_b_i,
	input  wire logic [acelp_pkg::OP_W-1:0] shr_a_i,
	input  wire logic [acelp_pkg::OP_W-1:0] shr_b_i,
	input  wire logic [acelp_pkg::OP_W-1:0] shl_a_i,
	input  wire logic [acelp_pkg::OP_W-1:0] shl_b_i,
	output logic      [acelp_pkg::OP_W-1:0] add_r_o,
	output logic      [acelp_pkg::OP_W-1:0] shr_r_o,
	output logic      [acelp_pkg::OP_W-1:0] shl_r_o
);

	localparam int W = acelp_pkg::OP_W;

	localparam logic [W-1:0] MAX_VAL = {1'b0, {(W-1){1'b1}}}; // 0x7fff
	localparam logic [W-1:0] MIN_VAL = {1'b1, {(W-1){1'b0}}}; // 0x8000

	////////////////////////////////////////////////////////////
	// operator helpers
	////////////////////////////////////////////////////////////

	// saturating add
	function automatic logic [W-1:0] sat_add(input logic [W-1:0] a, input logic [W-1:0] b);
		logic [W:0] sum;
		sum = {a[W-1], a} + {b[W-1], b};
		if (sum[W] != sum[W-1])
			return sum[W] ? MIN_VAL : MAX_VAL;
		return sum[W-1:0];
	endfunction

	// arithmetic right shift by a non-negative count
	function automatic logic [W-1:0] shr_cnt(input logic [W-1:0] a, input logic [W-1:0] n);
		if (n >= W'(W - 1))
			return {W{a[W-1]}}; // only the sign is left
		return $signed(a) >>> n;
	endfunction

	// left shift by a non-negative count, saturating on overflow
	function automatic logic [W-1:0] shl_cnt(input logic [W-1:0] a, input logic [W-1:0] n);
		logic [2*W-1:0] prod;
		logic           ovf;
		prod = {{W{a[W-1]}}, a} << n;
		if (n > W'(W - 1))
			ovf = (a != '0);
		else
			ovf = (prod != {{W{prod[W-1]}}, prod[W-1:0]});
		if (ovf)
			return a[W-1] ? MIN_VAL : MAX_VAL;
		return prod[W-1:0];
	endfunction

	////////////////////////////////////////////////////////////
	// operator outputs
	////////////////////////////////////////////////////////////
	always_comb
	begin
		add_r_o = sat_add(add_a_i, add_b_i);

		// a negative count flips the shift direction
		if (shr_b_i[W-1])
			shr_r_o = shl_cnt(shr_a_i, -shr_b_i);
		else
			shr_r_o = shr_cnt(shr_a_i, shr_b_i);

		if (shl_b_i[W-1])
			shl_r_o = shr_cnt(shl_a_i, -shl_b_i);
		else
			shl_r_o = shl_cnt(shl_a_i, shl_b_i);
	end

endmodule

`default_nettype wire

/* hw/scratch_mem.sv */
`default_nettype none

// scratch RAM shared by the decoder and the host
// one merged write port, two registered read ports
module scratch_mem #(
	parameter int ADDR_W = 12
) (
	input  wire logic                                  clk,
	// decoder side
	input  wire logic                                  core_we_i,
	input  wire logic [ADDR_W-1:0]                     core_waddr_i,
	input  wire logic [scratch_map_pkg::MEM_DATA_W-1:0] core_wdata_i,
	input  wire logic [ADDR_W-1:0]                     core_raddr_i,
	output logic      [scratch_map_pkg::MEM_DATA_W-1:0] core_rdata_o,
	// host side
	input  wire logic                                  host_we_i,
	input  wire logic [ADDR_W-1:0]                     host_addr_i,
	input  wire logic [scratch_map_pkg::MEM_DATA_W-1:0] host_wdata_i,
	output logic      [scratch_map_pkg::MEM_DATA_W-1:0] host_rdata_o
);

	logic [scratch_map_pkg::MEM_DATA_W-1:0] mem [2**ADDR_W];

	logic                                  wr_en;
	logic [ADDR_W-1:0]                     wr_addr;
	logic [scratch_map_pkg::MEM_DATA_W-1:0] wr_data;

	// decoder write wins when both ports write
	assign wr_en   = core_we_i | host_we_i;
	assign wr_addr = core_we_i ? core_waddr_i : host_addr_i;
	assign wr_data = core_we_i ? core_wdata_i : host_wdata_i;

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// read data one cycle after the address
	always_ff @(posedge clk)
	begin
		core_rdata_o <= mem[core_raddr_i];
		host_rdata_o <= mem[host_addr_i];
	end

endmodule

`default_nettype wire

/* hw/acelp_pulse_decoder.sv */
`default_nettype none

// fixed codebook decoder for one subframe
// all arithmetic goes through the external basic operator unit
module acelp_pulse_decoder #(
	parameter int ADDR_W = 12
) (
	input  wire logic                                   clk,
	input  wire logic                                   reset,
	input  wire logic                                   start_valid_i,
	output logic                                        start_ready_o,
	output logic                                        done_o,
	// operator unit
	output logic      [acelp_pkg::OP_W-1:0]             add_a_o,
	output logic      [acelp_pkg::OP_W-1:0]             add_b_o,
	output logic      [acelp_pkg::OP_W-1:0]             shr_a_o,
	output logic      [acelp_pkg::OP_W-1:0]             shr_b_o,
	output logic      [acelp_pkg::OP_W-1:0]             shl_a_o,
	output logic      [acelp_pkg::OP_W-1:0]             shl_b_o,
	input  wire logic [acelp_pkg::OP_W-1:0]             add_r_i,
	input  wire logic [acelp_pkg::OP_W-1:0]             shr_r_i,
	input  wire logic [acelp_pkg::OP_W-1:0]             shl_r_i,
	// scratch memory
	input  wire logic [scratch_map_pkg::MEM_DATA_W-1:0] mem_rdata_i,
	output logic      [ADDR_W-1:0]                      mem_raddr_o,
	output logic                                        mem_we_o,
	output logic      [ADDR_W-1:0]                      mem_waddr_o,
	output logic      [scratch_map_pkg::MEM_DATA_W-1:0] mem_wdata_o
);

	localparam int W  = acelp_pkg::OP_W;
	localparam int DW = scratch_map_pkg::MEM_DATA_W;
	localparam int PS = scratch_map_pkg::PAGE_SHIFT;

	localparam logic [4:0] ST_RESET     = 5'd0;
	localparam logic [4:0] ST_IDLE      = 5'd1;
	localparam logic [4:0] ST_GET_INDEX = 5'd2;
	localparam logic [4:0] ST_POS0      = 5'd3;
	localparam logic [4:0] ST_POS1_MUL  = 5'd4;
	localparam logic [4:0] ST_POS1      = 5'd5;
	localparam logic [4:0] ST_POS2_MUL  = 5'd6;
	localparam logic [4:0] ST_POS2      = 5'd7;
	localparam logic [4:0] ST_J         = 5'd8;
	localparam logic [4:0] ST_POS3_MUL  = 5'd9;
	localparam logic [4:0] ST_POS3_ADD  = 5'd10;
	localparam logic [4:0] ST_POS3      = 5'd11;
	localparam logic [4:0] ST_CLR_CHK   = 5'd12;
	localparam logic [4:0] ST_CLR_WR    = 5'd13;
	localparam logic [4:0] ST_GET_SIGN  = 5'd14;
	localparam logic [4:0] ST_SGN_CHK   = 5'd15;
	localparam logic [4:0] ST_SGN_WR    = 5'd16;
	localparam logic [4:0] ST_DONE      = 5'd17;

	logic [4:0]   state_q, state_d;
	logic [W-1:0] index_q, index_d;
	logic [W-1:0] sign_q, sign_d;
	logic [W-1:0] i_q, i_d;
	logic [W-1:0] j_q, j_d;
	logic [W-1:0] pos0_q, pos1_q, pos2_q, pos3_q;
	logic         ld_pos0, ld_pos1, ld_pos2, ld_pos3;
	logic [W-1:0] idx_low3, shr_low3, shr_low1, sign_bit;
	logic [W-1:0] cur_pos;
	logic [W-1:0] pulse_amp;

	// word address from page number and offset
	function automatic logic [ADDR_W-1:0] page_addr(input int unsigned page,
		input logic [PS-1:0] offs);
		return ADDR_W'(page << PS) | ADDR_W'(offs);
	endfunction

	assign start_ready_o = (state_q == ST_IDLE);
	assign done_o        = (state_q == ST_DONE);

	////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state_q <= ST_RESET;
			i_q     <= '0;
			j_q     <= '0;
		end
		else
		begin
			state_q <= state_d;
			i_q     <= i_d;
			j_q     <= j_d;
		end
	end

	always_ff @(posedge clk)
	begin
		index_q <= index_d;
		sign_q  <= sign_d;
		if (ld_pos0)
			pos0_q <= add_r_i;
		if (ld_pos1)
			pos1_q <= add_r_i;
		if (ld_pos2)
			pos2_q <= add_r_i;
		if (ld_pos3)
			pos3_q <= add_r_i;
	end

	// masked fields of the index and sign words
	assign idx_low3 = {{(W-3){1'b0}}, index_q[2:0]};
	assign shr_low3 = {{(W-3){1'b0}}, shr_r_i[2:0]};
	assign shr_low1 = {{(W-1){1'b0}}, shr_r_i[0]};
	assign sign_bit = {{(W-1){1'b0}}, sign_q[0]};

	// position of the pulse being placed
	always_comb
	begin
		case (j_q[1:0])
			2'd0: cur_pos = pos0_q;
			2'd1: cur_pos = pos1_q;
			2'd2: cur_pos = pos2_q;
			default: cur_pos = pos3_q;
		endcase
	end

	assign pulse_amp = (i_q != '0) ? acelp_pkg::PULSE_POS_AMP : acelp_pkg::PULSE_NEG_AMP;

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////
	always_comb
	begin
		state_d     = state_q;
		index_d     = index_q;
		sign_d      = sign_q;
		i_d         = i_q;
		j_d         = j_q;
		ld_pos0     = 1'b0;
		ld_pos1     = 1'b0;
		ld_pos2     = 1'b0;
		ld_pos3     = 1'b0;
		add_a_o     = '0;
		add_b_o     = '0;
		shr_a_o     = '0;
		shr_b_o     = '0;
		shl_a_o     = '0;
		shl_b_o     = '0;
		mem_raddr_o = '0;
		mem_we_o    = 1'b0;
		mem_waddr_o = '0;
		mem_wdata_o = '0;

		case (state_q)
			ST_RESET:
				state_d = ST_IDLE;
			ST_IDLE:
			begin
				mem_raddr_o = page_addr(scratch_map_pkg::INDEX_PAGE, '0);
				if (start_valid_i)
					state_d = ST_GET_INDEX;
			end
			ST_GET_INDEX:
			begin
				index_d = mem_rdata_i[W-1:0];
				state_d = ST_POS0;
			end
			ST_POS0:
			begin
				shl_a_o = idx_low3;
				shl_b_o = W'(2);
				add_a_o = idx_low3;
				add_b_o = shl_r_i; // i + 4i
				ld_pos0 = 1'b1;
				state_d = ST_POS1_MUL;
			end
			ST_POS1_MUL, ST_POS2_MUL:
			begin
				shr_a_o = index_q;
				shr_b_o = W'(3);
				index_d = shr_r_i; // next 3-bit field
				shl_a_o = shr_low3;
				shl_b_o = W'(2);
				add_a_o = shr_low3;
				add_b_o = shl_r_i;
				i_d     = add_r_i;
				state_d = (state_q == ST_POS1_MUL) ? ST_POS1 : ST_POS2;
			end
			ST_POS1:
			begin
				add_a_o = i_q;
				add_b_o = W'(1);
				ld_pos1 = 1'b1;
				state_d = ST_POS2_MUL;
			end
			ST_POS2:
			begin
				add_a_o = i_q;
				add_b_o = W'(2);
				ld_pos2 = 1'b1;
				state_d = ST_J;
			end
			ST_J:
			begin
				shr_a_o = index_q;
				shr_b_o = W'(3);
				index_d = shr_r_i;
				j_d     = shr_low1; // track 3 offset bit
				state_d = ST_POS3_MUL;
			end
			ST_POS3_MUL:
			begin
				shr_a_o = index_q;
				shr_b_o = W'(1);
				index_d = shr_r_i;
				shl_a_o = shr_low3;
				shl_b_o = W'(2);
				add_a_o = shr_low3;
				add_b_o = shl_r_i;
				i_d     = add_r_i;
				state_d = ST_POS3_ADD;
			end
			ST_POS3_ADD:
			begin
				add_a_o = i_q;
				add_b_o = W'(3);
				i_d     = add_r_i;
				state_d = ST_POS3;
			end
			ST_POS3:
			begin
				add_a_o = i_q;
				add_b_o = j_q;
				ld_pos3 = 1'b1;
				i_d     = '0; // clear loop starts at 0
				state_d = ST_CLR_CHK;
			end
			ST_CLR_CHK:
			begin
				if (i_q == acelp_pkg::L_SUBFR)
				begin
					j_d         = '0;
					mem_raddr_o = page_addr(scratch_map_pkg::SIGN_PAGE, '0);
					state_d     = ST_GET_SIGN;
				end
				else
					state_d = ST_CLR_WR;
			end
			ST_CLR_WR:
			begin
				mem_we_o    = 1'b1;
				mem_waddr_o = page_addr(scratch_map_pkg::COD_PAGE, i_q[PS-1:0]);
				add_a_o     = i_q;
				add_b_o     = W'(1);
				i_d         = add_r_i;
				state_d     = ST_CLR_CHK;
			end
			ST_GET_SIGN:
			begin
				sign_d  = mem_rdata_i[W-1:0];
				state_d = ST_SGN_CHK;
			end
			ST_SGN_CHK:
			begin
				if (j_q == acelp_pkg::NB_PULSE)
					state_d = ST_DONE;
				else
				begin
					i_d     = sign_bit; // sign of pulse j
					shr_a_o = sign_q;
					shr_b_o = W'(1);
					sign_d  = shr_r_i;
					state_d = ST_SGN_WR;
				end
			end
			ST_SGN_WR:
			begin
				mem_we_o    = 1'b1;
				mem_waddr_o = page_addr(scratch_map_pkg::COD_PAGE, cur_pos[PS-1:0]);
				mem_wdata_o = {{(DW-W){pulse_amp[W-1]}}, pulse_amp};
				add_a_o     = j_q;
				add_b_o     = W'(1);
				j_d         = add_r_i;
				state_d     = ST_SGN_CHK;
			end
			ST_DONE:
				state_d = ST_IDLE;
			default:
				state_d = ST_IDLE;
		endcase
	end

endmodule

`default_nettype wire

/* hw/acelp_decode_top.sv */
`default_nettype none

// fixed codebook decode: decoder, operator unit and scratch memory
module acelp_decode_top #(
	parameter int ADDR_W = 12
) (
	input  wire logic                                   clk,
	input  wire logic                                   reset,
	input  wire logic                                   start_valid_i,
	output logic                                        start_ready_o,
	output logic                                        done_o,
	// host port into scratch memory
	input  wire logic                                   host_we_i,
	input  wire logic [ADDR_W-1:0]                      host_addr_i,
	input  wire logic [scratch_map_pkg::MEM_DATA_W-1:0] host_wdata_i,
	output logic      [scratch_map_pkg::MEM_DATA_W-1:0] host_rdata_o
);

	// operator unit operands and results
	logic [acelp_pkg::OP_W-1:0] add_a, add_b, add_r;
	logic [acelp_pkg::OP_W-1:0] shr_a, shr_b, shr_r;
	logic [acelp_pkg::OP_W-1:0] shl_a, shl_b, shl_r;

	// decoder side of the memory
	logic                                  core_we;
	logic [ADDR_W-1:0]                     core_waddr, core_raddr;
	logic [scratch_map_pkg::MEM_DATA_W-1:0] core_wdata, core_rdata;

	acelp_pulse_decoder #(
		.ADDR_W(ADDR_W)
	) u_acelp_pulse_decoder (
		.clk           (clk),
		.reset         (reset),
		.start_valid_i (start_valid_i),
		.start_ready_o (start_ready_o),
		.done_o        (done_o),
		.add_a_o       (add_a),
		.add_b_o       (add_b),
		.shr_a_o       (shr_a),
		.shr_b_o       (shr_b),
		.shl_a_o       (shl_a),
		.shl_b_o       (shl_b),
		.add_r_i       (add_r),
		.shr_r_i       (shr_r),
		.shl_r_i       (shl_r),
		.mem_rdata_i   (core_rdata),
		.mem_raddr_o   (core_raddr),
		.mem_we_o      (core_we),
		.mem_waddr_o   (core_waddr),
		.mem_wdata_o   (core_wdata)
	);

	basic_op_unit u_basic_op_unit (
		.add_a_i (add_a),
		.add_b_i (add_b),
		.shr_a_i (shr_a),
		.shr_b_i (shr_b),
		.shl_a_i (shl_a),
		.shl_b_i (shl_b),
		.add_r_o (add_r),
		.shr_r_o (shr_r),
		.shl_r_o (shl_r)
	);

	scratch_mem #(
		.ADDR_W(ADDR_W)
	) u_scratch_mem (
		.clk          (clk),
		.core_we_i    (core_we),
		.core_waddr_i (core_waddr),
		.core_wdata_i (core_wdata),
		.core_raddr_i (core_raddr),
		.core_rdata_o (core_rdata),
		.host_we_i    (host_we_i),
		.host_addr_i  (host_addr_i),
		.host_wdata_i (host_wdata_i),
		.host_rdata_o (host_rdata_o)
	);

endmodule

`default_nettype wire

/* sim/acelp_decode_assert.sv */
`default_nettype none

// start handshake and done timing checks bound into the top level
module acelp_decode_assert (
	input wire logic clk,
	input wire logic reset,
	input wire logic start_valid_i,
	input wire logic start_ready_i,
	input wire logic done_i
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [7:0] DONE_LAT = 8'd102; // edges from accept to done

	logic       accept;
	logic [7:0] busy_cnt; // edges since the accepting edge or zero when idle
	int         fail_cnt = 0; // count of failed assertions

	assign accept = start_valid_i && start_ready_i;

	always_ff @(posedge clk)
	begin
		if (reset)
			busy_cnt <= '0;
		else if (accept)
			busy_cnt <= 8'd1;
		else if (busy_cnt == DONE_LAT)
			busy_cnt <= '0;
		else if (busy_cnt != '0)
			busy_cnt <= busy_cnt + 8'd1;
	end

	////////////////////////////////////////////////////////////
	// done and ready timing
	////////////////////////////////////////////////////////////
	assert property (@(posedge clk) disable iff (reset) done_i |-> busy_cnt == DONE_LAT)
		else
		begin
			fail_cnt++;
			$error("done_o high outside the expected cycle after accept");
		end
	assert property (@(posedge clk) disable iff (reset) busy_cnt == DONE_LAT |-> done_i)
		else
		begin
			fail_cnt++;
			$error("done_o missing 102 cycles after accept");
		end
	assert property (@(posedge clk) disable iff (reset) busy_cnt != '0 |-> !start_ready_i)
		else
		begin
			fail_cnt++;
			$error("start_ready_o high while the decoder is busy");
		end
	assert property (@(posedge clk) disable iff (reset) busy_cnt == DONE_LAT |=> start_ready_i)
		else
		begin
			fail_cnt++;
			$error("start_ready_o did not return after done_o");
		end
	assert property (@(posedge clk) disable iff (reset) accept |-> busy_cnt == '0)
		else
		begin
			fail_cnt++;
			$error("start request accepted while busy");
		end

	// idle state around reset
	assert property (@(posedge clk) $past(reset) |-> !done_i && !start_ready_i)
		else
		begin
			fail_cnt++;
			$error("done_o or start_ready_o high during reset");
		end
	assert property (@(posedge clk) $past(reset) && !reset |=> start_ready_i)
		else
		begin
			fail_cnt++;
			$error("start_ready_o did not rise one cycle after reset release");
		end

endmodule

bind acelp_decode_top acelp_decode_assert u_acelp_decode_assert (
	.clk           (clk),
	.reset         (reset),
	.start_valid_i (start_valid_i),
	.start_ready_i (start_ready_o),
	.done_i        (done_o)
);

`default_nettype wire

/* sim/acelp_decode_tb.sv */
`default_nettype none

module acelp_decode_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ADDR_W       = 12;
	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 10;
	localparam int N_DIRECTED   = 6;
	localparam int N_RANDOM     = 30;
	localparam int N_TRIALS     = N_DIRECTED + N_RANDOM;
	localparam int TRIAL_CYCLES = 250;
	localparam int DONE_TIMEOUT = 200;
	localparam int WATCHDOG_NS  = (RESET_CYCLES + N_TRIALS * TRIAL_CYCLES) * CLK_PERIOD;

	localparam int PS         = scratch_map_pkg::PAGE_SHIFT;
	localparam int INDEX_BASE = scratch_map_pkg::INDEX_PAGE << PS;
	localparam int SIGN_BASE  = scratch_map_pkg::SIGN_PAGE << PS;
	localparam int COD_BASE   = scratch_map_pkg::COD_PAGE << PS;

	logic              clk = 1'b0;
	logic              reset;
	logic              start_valid;
	logic              start_ready;
	logic              done;
	logic              host_we;
	logic [ADDR_W-1:0] host_addr;
	logic [31:0]       host_wdata;
	logic [31:0]       host_rdata;

	logic [15:0] lfsr_state = 16'd56957;
	logic [31:0] cod_rd [40]; // words read back from the cod page
	int          err_words = 0;
	int          err_other = 0;
	bit          aborted = 1'b0;

	acelp_decode_top #(
		.ADDR_W(ADDR_W)
	) u_acelp_decode_top (
		.clk           (clk),
		.reset         (reset),
		.start_valid_i (start_valid),
		.start_ready_o (start_ready),
		.done_o        (done),
		.host_we_i     (host_we),
		.host_addr_i   (host_addr),
		.host_wdata_i  (host_wdata),
		.host_rdata_o  (host_rdata)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// random bits and directed cases
	////////////////////////////////////////////////////////////
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400; // x^16 + x^14 + x^13 + x^11 + 1
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int b = 0; b < n; b++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	function automatic logic [15:0] directed_index(input int k);
		case (k)
			0: return 16'h0000;   // every field 0
			1: return 16'h1FFF;   // every field 7, j set, pos3 = 39
			2: return 16'h1DFF;   // every field 7, j clear
			3: return 16'h0238;   // only i1 and j
			4: return 16'hE1C7;   // bits 15:13 set
			default: return 16'hFFFF;
		endcase
	endfunction

	function automatic logic [15:0] directed_sign(input int k);
		case (k)
			0: return 16'h0000;
			1: return 16'h000F;
			2: return 16'h0005;
			3: return 16'h000A;
			4: return 16'hFFF3; // upper sign bits are junk
			default: return 16'hA5A9;
		endcase
	endfunction

	// expected cod word from the track and sign rules
	function automatic logic [31:0] expected_word(input logic [15:0] idx,
		input logic [15:0] sgn, input int k);
		int          pos [4];
		logic [31:0] w;
		pos[0] = 5 * int'(idx[2:0]);
		pos[1] = 5 * int'(idx[5:3]) + 1;
		pos[2] = 5 * int'(idx[8:6]) + 2;
		pos[3] = 5 * int'(idx[12:10]) + 3 + int'(idx[9]);
		w = 32'h0000_0000;
		for (int p = 0; p < 4; p++)
			if (pos[p] == k)
				w = sgn[p] ? 32'h0000_1FFF : 32'hFFFF_E000; // +8191 or -8192
		return w;
	endfunction

	////////////////////////////////////////////////////////////
	// host port
	////////////////////////////////////////////////////////////
	task automatic write_word(input int addr, input logic [31:0] data);
		@(posedge clk);
		host_we    <= 1'b1;
		host_addr  <= ADDR_W'(addr);
		host_wdata <= data;
	endtask

	// pipelined readback of one word per cycle
	task automatic read_cod();
		for (int k = 0; k <= 40; k++)
		begin
			@(posedge clk);
			if (k < 40)
				host_addr <= ADDR_W'(COD_BASE + k);
			@(negedge clk);
			if (k > 0)
				cod_rd[k-1] = host_rdata;
		end
	endtask

	task automatic run_trial(input string name, input logic [15:0] idx, input logic [15:0] sgn);
		logic [31:0] junk;
		logic [31:0] exp;
		int          wait_cnt;
		for (int k = 0; k < 40; k++)
		begin
			take_bits(32, junk);
			write_word(COD_BASE + k, junk); // stale data the clear must remove
		end
		write_word(INDEX_BASE, {16'h0000, idx});
		write_word(SIGN_BASE, {16'h0000, sgn});
		@(posedge clk);
		host_we     <= 1'b0;
		start_valid <= 1'b1; // held through the busy phase
		wait_cnt = 0;
		do
		begin
			@(negedge clk);
			wait_cnt++;
		end
		while (done !== 1'b1 && wait_cnt < DONE_TIMEOUT);
		if (done !== 1'b1)
		begin
			$display("%s: done_o did not arrive within %0d cycles", name, DONE_TIMEOUT);
			err_other++;
			aborted = 1'b1;
			return;
		end
		@(posedge clk);
		start_valid <= 1'b0;
		read_cod();
		for (int k = 0; k < 40; k++)
		begin
			exp = expected_word(idx, sgn, k);
			if (cod_rd[k] !== exp)
			begin
				$display("FAILED %s cod[%0d] expected %08h actual %08h", name, k, exp, cod_rd[k]);
				err_words++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		logic [31:0] r;
		logic [15:0] idx;
		logic [15:0] sgn;
		int          err_assert;
		reset       = 1'b1;
		start_valid = 1'b0;
		host_we     = 1'b0;
		host_addr   = '0;
		host_wdata  = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		for (int t = 0; t < N_TRIALS && !aborted; t++)
		begin
			if (t < N_DIRECTED)
			begin
				idx = directed_index(t);
				sgn = directed_sign(t);
				run_trial($sformatf("directed_%0d", t), idx, sgn);
			end
			else
			begin
				take_bits(16, r);
				idx = r[15:0];
				take_bits(16, r);
				sgn = r[15:0];
				run_trial($sformatf("random_%0d", t - N_DIRECTED), idx, sgn);
			end
		end

		err_assert = u_acelp_decode_top.u_acelp_decode_assert.fail_cnt;
		$display("errors: %0d wrong words, %0d assertion failures, %0d other",
			err_words, err_assert, err_other);
		if (err_words == 0 && err_other == 0 && err_assert == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// watchdog
	initial
	begin
		#WATCHDOG_NS;
		$display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
hw/acelp_pkg.sv
hw/scratch_map_pkg.sv
hw/basic_op_unit.sv
hw/scratch_mem.sv
hw/acelp_pulse_decoder.sv
hw/acelp_decode_top.sv
sim/acelp_decode_assert.sv
sim/acelp_decode_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fixed codebook decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module acelp_decode_tb -f sources.f \
	-Mdir "$BUILD_DIR" -o acelp_decode_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/acelp_decode_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
	exit 0
fi
exit 1
